// ==== hw/sifh_pkg.sv ====
package sifh_pkg;

    // histogram geometry
    localparam int NUM_BINS = 16;
    localparam int BIN_W    = 4;
    // counts stop at 255
    localparam int COUNT_W  = 8;
    // up to 8 pixels per array
    localparam int PIX_W    = 3;

    // raw timestamp from the TDC
    localparam int STAMP_W  = 12;
    // coarse window field, everything above the fine bin
    localparam int WIN_W    = STAMP_W - BIN_W;

    // coarse view, top bits pick the bin
    typedef struct packed {
        logic [BIN_W-1:0]         coarse;
        logic [STAMP_W-BIN_W-1:0] unused;
    } tof_ch_t;

    // fine view, window match gates the low bits
    typedef struct packed {
        logic [WIN_W-1:0] window;
        logic [BIN_W-1:0] fine;
    } tof_fh_t;

    // one stamp word, two decodings
    typedef union packed {
        tof_ch_t ch;
        tof_fh_t fh;
    } tof_word_u;

    typedef enum logic {
        MODE_CH = 1'b0,
        MODE_FH = 1'b1
    } hist_mode_e;

    // mapper result, one per stamp strobe
    typedef struct packed {
        logic             valid;
        logic             hit;
        logic [BIN_W-1:0] bin;
    } hist_evt_t;

    // increment request into the bank
    typedef struct packed {
        logic             en;
        logic             page;
        logic [PIX_W-1:0] pixel;
        logic [BIN_W-1:0] bin;
    } his_wr_t;

    // streamed histogram entry
    typedef struct packed {
        logic               valid;
        logic [PIX_W-1:0]   pixel;
        logic [BIN_W-1:0]   bin;
        logic [COUNT_W-1:0] count;
    } hist_word_t;

endpackage

// ==== hw/tof_bin_mapper.sv ====
`timescale 1ns/1ps

module tof_bin_mapper (
    input  logic                         clk,
    input  logic                         combin_res,
    input  logic                         stamp_valid,
    input  sifh_pkg::tof_word_u          stamp,
    input  sifh_pkg::hist_mode_e         mode,
    input  logic [sifh_pkg::WIN_W-1:0]   fh_window,
    output sifh_pkg::hist_evt_t          evt
);

    import sifh_pkg::*;

    // decoded stamp before the register
    logic             hit_d;
    logic [BIN_W-1:0] bin_d;

    // pick the view of the stamp word by mode
    always_comb begin
        case (mode)
            MODE_FH: begin
                // only the selected coarse window counts
                hit_d = (stamp.fh.window == fh_window);
                bin_d = stamp.fh.fine;
            end
            default: begin
                // coarse mode, every stamp lands somewhere
                hit_d = 1'b1;
                bin_d = stamp.ch.coarse;
            end
        endcase
    end

    // one register stage, evt follows the sampling edge
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            evt <= '0;
        end else begin
            evt.valid <= stamp_valid;
            // rejected stamps still go out as shots, just without hit
            evt.hit   <= stamp_valid && hit_d;
            evt.bin   <= bin_d;
        end
    end

    // the pixel front end must hand over a clean word with every strobe
    a_stamp_known: assert property (
        @(posedge clk) disable iff (!combin_res)
        stamp_valid |-> !$isunknown(stamp)
    );

endmodule

// ==== hw/acq_sequencer.sv ====
`timescale 1ns/1ps

module acq_sequencer #(
    parameter int NUM_PIXELS       = 4,
    parameter int STAMPS_PER_PIXEL = 3,
    parameter int ACQ_PER_FRAME    = 2
) (
    input  logic                 clk,
    input  logic                 combin_res,
    input  sifh_pkg::hist_evt_t  evt,
    output sifh_pkg::his_wr_t    wr,
    output logic                 frame_done,
    output logic                 page_sel
);

    import sifh_pkg::*;

    // counter widths, at least one bit each
    localparam int SHOT_W = (STAMPS_PER_PIXEL > 1) ? $clog2(STAMPS_PER_PIXEL) : 1;
    localparam int ACQ_W  = (ACQ_PER_FRAME > 1) ? $clog2(ACQ_PER_FRAME) : 1;

    logic [SHOT_W-1:0] shot_cnt;
    logic [PIX_W-1:0]  pix_cnt;
    logic [ACQ_W-1:0]  acq_cnt;

    // terminal counts of the nested loops
    logic shot_last;
    logic pix_last;
    logic acq_last;
    logic frame_last;

    assign shot_last  = (shot_cnt == SHOT_W'(STAMPS_PER_PIXEL - 1));
    assign pix_last   = (pix_cnt == PIX_W'(NUM_PIXELS - 1));
    assign acq_last   = (acq_cnt == ACQ_W'(ACQ_PER_FRAME - 1));
    assign frame_last = shot_last && pix_last && acq_last;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            shot_cnt   <= '0;
            pix_cnt    <= '0;
            acq_cnt    <= '0;
            wr         <= '0;
            frame_done <= 1'b0;
            page_sel   <= 1'b0;
        end else begin
            // write tagged with the pixel and page before any advance
            wr.en      <= evt.valid && evt.hit;
            wr.page    <= page_sel;
            wr.pixel   <= pix_cnt;
            wr.bin     <= evt.bin;
            // pulse lines up with the last shot's write
            frame_done <= evt.valid && frame_last;

            // every strobe is a shot, hit or not
            if (evt.valid) begin
                if (!shot_last) begin
                    shot_cnt <= shot_cnt + 1'b1;
                end else begin
                    shot_cnt <= '0;
                    if (!pix_last) begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end else begin
                        pix_cnt <= '0;
                        if (!acq_last) begin
                            acq_cnt <= acq_cnt + 1'b1;
                        end else begin
                            // frame over, swap fill and readout pages
                            acq_cnt  <= '0;
                            page_sel <= ~page_sel;
                        end
                    end
                end
            end
        end
    end

    // bank is sized for NUM_PIXELS, a stray pixel index would alias
    a_pixel_in_range: assert property (
        @(posedge clk) disable iff (!combin_res)
        wr.en |-> (int'(wr.pixel) < NUM_PIXELS)
    );

endmodule

// ==== hw/his_bank.sv ====
`timescale 1ns/1ps

module his_bank #(
    parameter int NUM_PIXELS = 4
) (
    input  logic                          clk,
    input  logic                          combin_res,
    input  sifh_pkg::his_wr_t             wr,
    input  logic                          rd_en,
    input  logic                          rd_page,
    input  logic [sifh_pkg::PIX_W-1:0]    rd_pixel,
    input  logic [sifh_pkg::BIN_W-1:0]    rd_bin,
    output logic [sifh_pkg::COUNT_W-1:0]  rd_count
);

    import sifh_pkg::*;

    // both pages in one flat array, page is the top of the index
    localparam int PAGE_DEPTH = NUM_PIXELS * NUM_BINS;
    localparam int DEPTH      = 2 * PAGE_DEPTH;

    logic [COUNT_W-1:0] mem [DEPTH];
    // set on first hit, cleared on readout
    logic [DEPTH-1:0]   ent_valid;

    logic [COUNT_W-1:0] wr_next;
    int                 wr_idx;
    int                 rd_idx;

    function automatic int entry_idx(
        input logic             page,
        input logic [PIX_W-1:0] pixel,
        input logic [BIN_W-1:0] bin
    );
        return int'(page) * PAGE_DEPTH + int'(pixel) * NUM_BINS + int'(bin);
    endfunction

    assign wr_idx = entry_idx(wr.page, wr.pixel, wr.bin);
    assign rd_idx = entry_idx(rd_page, rd_pixel, rd_bin);

    // next count for the write port
    always_comb begin
        if (!ent_valid[wr_idx]) begin
            // stale entry from an older frame, restart at one
            wr_next = COUNT_W'(1);
        end else if (mem[wr_idx] == '1) begin
            // saturate
            wr_next = mem[wr_idx];
        end else begin
            wr_next = mem[wr_idx] + 1'b1;
        end
    end

    // validity bits, the only state that needs a clear
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            ent_valid <= '0;
        end else begin
            if (wr.en) begin
                ent_valid[wr_idx] <= 1'b1;
            end
            // read-and-clear, pages never collide so no priority issue
            if (rd_en) begin
                ent_valid[rd_idx] <= 1'b0;
            end
        end
    end

    // counter storage and registered read port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr_idx] <= wr_next;
        end
        if (rd_en) begin
            // invalid entry reads as an empty bin
            rd_count <= ent_valid[rd_idx] ? mem[rd_idx] : '0;
        end
    end

    // fill page and readout page must stay apart
    a_page_split: assert property (
        @(posedge clk) disable iff (!combin_res)
        !(wr.en && rd_en && (wr.page == rd_page))
    );

endmodule

// ==== hw/his_readout.sv ====
`timescale 1ns/1ps

module his_readout #(
    parameter int NUM_PIXELS = 4
) (
    input  logic                          clk,
    input  logic                          combin_res,
    input  logic                          frame_done,
    input  logic                          page_sel,
    output logic                          rd_en,
    output logic                          rd_page,
    output logic [sifh_pkg::PIX_W-1:0]    rd_pixel,
    output logic [sifh_pkg::BIN_W-1:0]    rd_bin,
    input  logic [sifh_pkg::COUNT_W-1:0]  rd_count,
    output sifh_pkg::hist_word_t          hist_out,
    output logic                          overrun
);

    import sifh_pkg::*;

    logic busy;
    logic bin_last;
    logic walk_last;

    // address stage aligned with rd_count
    logic             s1_valid;
    logic [PIX_W-1:0] s1_pixel;
    logic [BIN_W-1:0] s1_bin;

    assign bin_last  = (rd_bin == BIN_W'(NUM_BINS - 1));
    assign walk_last = bin_last && (rd_pixel == PIX_W'(NUM_PIXELS - 1));

    // one read per cycle while walking
    assign rd_en = busy;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            busy     <= 1'b0;
            rd_page  <= 1'b0;
            rd_pixel <= '0;
            rd_bin   <= '0;
            overrun  <= 1'b0;
            s1_valid <= 1'b0;
            s1_pixel <= '0;
            s1_bin   <= '0;
            hist_out <= '0;
        end else begin
            if (frame_done && !busy) begin
                // page_sel has already flipped so read the other one
                busy     <= 1'b1;
                rd_page  <= ~page_sel;
                rd_pixel <= '0;
                rd_bin   <= '0;
            end else if (busy) begin
                // pixel-major with bins ascending
                rd_bin <= bin_last ? '0 : rd_bin + 1'b1;
                if (bin_last) begin
                    rd_pixel <= walk_last ? '0 : rd_pixel + 1'b1;
                end
                if (walk_last) begin
                    busy <= 1'b0;
                end
            end

            // a new frame while still streaming is dropped and flagged
            if (frame_done && busy) begin
                overrun <= 1'b1;
            end

            s1_valid <= busy;
            s1_pixel <= rd_pixel;
            s1_bin   <= rd_bin;

            hist_out.valid <= s1_valid;
            hist_out.pixel <= s1_pixel;
            hist_out.bin   <= s1_bin;
            hist_out.count <= s1_valid ? rd_count : '0;
        end
    end

    // back to back words inside one walk step through the bins in order
    a_walk_order: assert property (
        @(posedge clk) disable iff (!combin_res)
        (hist_out.valid && $past(hist_out.valid)) |->
            (hist_out.bin == BIN_W'($past(hist_out.bin) + 1'b1))
    );

endmodule

// ==== hw/sifh_histogrammer_top.sv ====
`timescale 1ns/1ps

module sifh_histogrammer_top #(
    parameter int NUM_PIXELS       = 4,
    parameter int STAMPS_PER_PIXEL = 3,
    parameter int ACQ_PER_FRAME    = 2
) (
    input  logic                        clk,
    input  logic                        combin_res,
    input  logic                        stamp_valid,
    input  sifh_pkg::tof_word_u         stamp,
    input  sifh_pkg::hist_mode_e        mode,
    input  logic [sifh_pkg::WIN_W-1:0]  fh_window,
    output sifh_pkg::hist_word_t        hist_out,
    output logic                        frame_done,
    output logic                        page_sel,
    output logic                        overrun
);

    import sifh_pkg::*;

    // mapper to sequencer
    hist_evt_t          evt;
    // sequencer to bank
    his_wr_t            wr;
    // readout port of the bank
    logic               rd_en;
    logic               rd_page;
    logic [PIX_W-1:0]   rd_pixel;
    logic [BIN_W-1:0]   rd_bin;
    logic [COUNT_W-1:0] rd_count;

    tof_bin_mapper u_mapper (
        .clk         (clk),
        .combin_res  (combin_res),
        .stamp_valid (stamp_valid),
        .stamp       (stamp),
        .mode        (mode),
        .fh_window   (fh_window),
        .evt         (evt)
    );

    acq_sequencer #(
        .NUM_PIXELS       (NUM_PIXELS),
        .STAMPS_PER_PIXEL (STAMPS_PER_PIXEL),
        .ACQ_PER_FRAME    (ACQ_PER_FRAME)
    ) u_sequencer (
        .clk        (clk),
        .combin_res (combin_res),
        .evt        (evt),
        .wr         (wr),
        .frame_done (frame_done),
        .page_sel   (page_sel)
    );

    his_bank #(
        .NUM_PIXELS (NUM_PIXELS)
    ) u_bank (
        .clk        (clk),
        .combin_res (combin_res),
        .wr         (wr),
        .rd_en      (rd_en),
        .rd_page    (rd_page),
        .rd_pixel   (rd_pixel),
        .rd_bin     (rd_bin),
        .rd_count   (rd_count)
    );

    // streams the page that just finished filling
    his_readout #(
        .NUM_PIXELS (NUM_PIXELS)
    ) u_readout (
        .clk        (clk),
        .combin_res (combin_res),
        .frame_done (frame_done),
        .page_sel   (page_sel),
        .rd_en      (rd_en),
        .rd_page    (rd_page),
        .rd_pixel   (rd_pixel),
        .rd_bin     (rd_bin),
        .rd_count   (rd_count),
        .hist_out   (hist_out),
        .overrun    (overrun)
    );

endmodule

// ==== dv/tb_sifh_histogrammer.sv ====
`timescale 1ns/1ps

module tb_sifh_histogrammer #(
    parameter int NUM_PIXELS       = 4,
    parameter int STAMPS_PER_PIXEL = 3,
    parameter int ACQ_PER_FRAME    = 2
);

    import sifh_pkg::*;

    // shots per frame and cycles per readout walk
    localparam int SHOTS    = NUM_PIXELS * STAMPS_PER_PIXEL * ACQ_PER_FRAME;
    localparam int READ_LEN = NUM_PIXELS * NUM_BINS;
    // 8 frames in total and at most 7 cycles per shot
    localparam int LIMIT    = 8 * (SHOTS * 7 + READ_LEN + 20) + 500;

    // stimulus styles
    localparam int ST_RANDOM = 0;
    localparam int ST_WINDOW = 1;
    localparam int ST_BURST  = 2;

    logic             clk;
    logic             combin_res;
    logic             stamp_valid;
    tof_word_u        stamp;
    hist_mode_e       mode;
    logic [WIN_W-1:0] fh_window;
    hist_word_t       hist_out;
    logic             frame_done;
    logic             page_sel;
    logic             overrun;

    integer seed;

    // reference model with two pages of expected counts
    int unsigned cnt [2][NUM_PIXELS][NUM_BINS];
    hist_word_t  exp_q [$];
    int          shot;
    int          pix;
    int          acq;
    // cycles of readout walk still ahead
    int          rd_left;
    logic        page_exp;
    logic        fin_page;
    logic        fd_exp;
    logic        ovr_exp;

    sifh_histogrammer_top #(
        .NUM_PIXELS       (NUM_PIXELS),
        .STAMPS_PER_PIXEL (STAMPS_PER_PIXEL),
        .ACQ_PER_FRAME    (ACQ_PER_FRAME)
    ) DUT (
        .clk         (clk),
        .combin_res  (combin_res),
        .stamp_valid (stamp_valid),
        .stamp       (stamp),
        .mode        (mode),
        .fh_window   (fh_window),
        .hist_out    (hist_out),
        .frame_done  (frame_done),
        .page_sel    (page_sel),
        .overrun     (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_word(input hist_word_t got, input hist_word_t exp);
        string got_s;
        string exp_s;
        if (got !== exp) begin
            got_s = $sformatf("v%b pix %0d bin %0d cnt %0d",
                              got.valid, got.pixel, got.bin, got.count);
            exp_s = $sformatf("v%b pix %0d bin %0d cnt %0d",
                              exp.valid, exp.pixel, exp.bin, exp.count);
            $display("MISMATCH at %0t: hist_out got %s expected %s", $time, got_s, exp_s);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // queue the expected stream of a finished page and clear it like the bank does
    task automatic queue_page(input logic pg);
        hist_word_t w;
        for (int p = 0; p < NUM_PIXELS; p++) begin
            for (int b = 0; b < NUM_BINS; b++) begin
                w.valid = 1'b1;
                w.pixel = PIX_W'(p);
                w.bin   = BIN_W'(b);
                w.count = COUNT_W'(cnt[pg][p][b]);
                exp_q.push_back(w);
                cnt[pg][p][b] = 0;
            end
        end
    endtask

    // check outputs at the falling edge and then step the model
    task automatic tick();
        logic [STAMP_W-1:0] raw;
        logic               hit;
        logic [BIN_W-1:0]   bin;
        @(negedge clk);
        check_flag("overrun", overrun, ovr_exp);
        check_flag("frame_done", frame_done, fd_exp);
        // page flips on the same edge as frame_done
        if (fd_exp) begin
            page_exp = ~page_exp;
        end
        check_flag("page_sel", page_sel, page_exp);
        if (hist_out.valid) begin
            if (exp_q.size() == 0) begin
                report_error("histogram word streamed with no finished frame pending");
            end
            check_word(hist_out, exp_q.pop_front());
        end
        // one walk at a time so a frame ending mid-walk is dropped
        if (fd_exp) begin
            if (rd_left != 0) begin
                ovr_exp = 1'b1;
            end else begin
                queue_page(fin_page);
                rd_left = READ_LEN + 1;
            end
        end
        if (rd_left != 0) begin
            rd_left--;
        end
        fd_exp = 1'b0;
        // stamp sampled at the last rising edge
        if (stamp_valid) begin
            raw = stamp;
            if (mode == MODE_FH) begin
                hit = (raw[STAMP_W-1:BIN_W] == fh_window);
                bin = raw[BIN_W-1:0];
            end else begin
                hit = 1'b1;
                bin = raw[STAMP_W-1 -: BIN_W];
            end
            // counts stop at 255
            if (hit && cnt[page_exp][pix][bin] < 255) begin
                cnt[page_exp][pix][bin]++;
            end
            // every strobe is a shot whether it hits or not
            shot++;
            if (shot == STAMPS_PER_PIXEL) begin
                shot = 0;
                pix++;
                if (pix == NUM_PIXELS) begin
                    pix = 0;
                    acq++;
                    if (acq == ACQ_PER_FRAME) begin
                        acq      = 0;
                        fd_exp   = 1'b1;
                        fin_page = page_exp;
                    end
                end
            end
        end
    endtask

    // random gaps keep a frame of stamps longer than a readout
    task automatic run_frame(input int style, input bit back_to_back);
        logic [STAMP_W-1:0] raw;
        for (int i = 0; i < SHOTS; i++) begin
            raw = STAMP_W'($random(seed));
            if (style == ST_WINDOW && ($random(seed) & 1)) begin
                raw[STAMP_W-1:BIN_W] = fh_window;
            end
            // all burst stamps on coarse bin 5
            if (style == ST_BURST) begin
                raw[STAMP_W-1 -: BIN_W] = BIN_W'(5);
            end
            stamp_valid = 1'b1;
            stamp       = raw;
            tick();
            stamp_valid = 1'b0;
            stamp       = STAMP_W'($random(seed));
            if (!back_to_back) begin
                repeat (3 + ($random(seed) & 3)) tick();
            end
        end
    endtask

    // let the pending readout finish
    task automatic drain();
        while (exp_q.size() != 0 || rd_left != 0 || fd_exp) begin
            tick();
        end
        repeat (4) tick();
    endtask

    initial begin
        repeat (LIMIT) @(posedge clk);
        report_error("watchdog expired, readout or frame_done never arrived");
    end

    initial begin
        seed        = 26;
        combin_res  = 1'b0;
        stamp_valid = 1'b0;
        stamp       = '0;
        mode        = MODE_CH;
        fh_window   = WIN_W'(8'h5a);
        shot        = 0;
        pix         = 0;
        acq         = 0;
        rd_left     = 0;
        page_exp    = 1'b0;
        fin_page    = 1'b0;
        fd_exp      = 1'b0;
        ovr_exp     = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        combin_res = 1'b1;

        // coarse mode where frame 3 reuses the page of frame 1
        repeat (3) run_frame(ST_RANDOM, 1'b0);
        drain();
        // fine mode with about half the stamps inside the window
        mode = MODE_FH;
        repeat (2) run_frame(ST_WINDOW, 1'b0);
        drain();
        // one bin hammered until it saturates in a long frame build
        mode = MODE_CH;
        run_frame(ST_BURST, 1'b0);
        drain();
        // without gaps the second frame ends inside the first walk
        repeat (2) run_frame(ST_RANDOM, 1'b1);
        drain();

        if (exp_q.size() != 0 || shot != 0) begin
            report_error("run ended with expected histogram words still outstanding");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
hw/sifh_pkg.sv
hw/tof_bin_mapper.sv
hw/acq_sequencer.sv
hw/his_bank.sv
hw/his_readout.sv
hw/sifh_histogrammer_top.sv
dv/tb_sifh_histogrammer.sv

// ==== Makefile ====
TOP := tb_sifh_histogrammer

.PHONY: help test clean

help:
	@echo "make test  - build and run the testbench with Verilator (default and long-frame builds)"
	@echo "make clean - remove build directories and logs"
	@echo "make help  - show this list"

test:
	verilator --binary --assert -Wno-fatal -f filelist.f --top-module $(TOP) -Mdir obj_base
	verilator --binary --assert -Wno-fatal -f filelist.f --top-module $(TOP) \
		-GSTAMPS_PER_PIXEL=300 -Mdir obj_sat
	-./obj_base/V$(TOP) > sim_base.log 2>&1
	-./obj_sat/V$(TOP) > sim_sat.log 2>&1
	@if grep -q "Done: errors found" sim_base.log sim_sat.log; then \
		echo "TEST FAILED"; exit 1; \
	elif ! grep -q "Done: no errors" sim_base.log || ! grep -q "Done: no errors" sim_sat.log; then \
		echo "TEST FAILED, simulation did not finish"; exit 1; \
	else \
		echo "TEST PASSED"; \
	fi

clean:
	rm -rf obj_base obj_sat sim_base.log sim_sat.log
